//--- conv_pkg.sv
package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // word and counter widths
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 16;
    localparam int SIZE_W = 16;
    localparam int DIM_W  = 16;

    typedef logic [ADDR_W-1:0] addr_t;  // buffer line address
    typedef logic [SIZE_W-1:0] size_t;  // sizes, indices, counters
    typedef logic [DIM_W-1:0]  dim_t;   // layer configuration field

    //////////////////////////////////////////////////////////////////////
    // sequencer states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        S_IDLE,
        S_FB,    // filter block loop
        S_CB,    // channel block loop
        S_SLOT,  // loader kicked off, first kernel read
        S_PUSH,  // kernels and bias being pushed
        S_IMG    // image streaming until write-back ends
    } seq_state_t;

    //////////////////////////////////////////////////////////////////////
    // default array size and datapath latencies
    //////////////////////////////////////////////////////////////////////
    localparam int N_PE_DEF         = 4;
    localparam int LAT_MAC_DEF      = 2;
    localparam int LAT_ADD_TREE_DEF = 5;
    localparam int LAT_FB_ADD_DEF   = 1;

endpackage

//--- conv_geometry.sv
`timescale 1ns/10ps

module conv_geometry import conv_pkg::*; #(
    parameter int N_PE         = N_PE_DEF,
    parameter int LAT_MAC      = LAT_MAC_DEF,
    parameter int LAT_ADD_TREE = LAT_ADD_TREE_DEF,
    parameter int LAT_FB_ADD   = LAT_FB_ADD_DEF
) (
    input  dim_t  data_wid,
    input  dim_t  data_hei,
    input  dim_t  filter_wid,
    input  dim_t  filter_hei,
    input  dim_t  channels,
    input  dim_t  filters,
    output size_t in_size,
    output size_t out_wid,
    output size_t out_size,
    output size_t filt_size,
    output size_t row_period,
    output size_t fb_cnt,
    output size_t cb_cnt,
    output size_t win_lat,
    output size_t wb_delay,
    output size_t fbrd_delay,
    output size_t fben_delay
);

    localparam int    LOG_NPE  = $clog2(N_PE);
    localparam size_t PIPE_LAT = size_t'(LAT_MAC + LAT_ADD_TREE); // mac + adder tree
    localparam size_t FB_LAT   = size_t'(LAT_FB_ADD);

    size_t out_hei;

    // stride 1, no padding
    assign in_size    = data_wid * data_hei;
    assign out_wid    = data_wid - filter_wid + 16'd1;
    assign out_hei    = data_hei - filter_hei + 16'd1;
    assign out_size   = out_wid * out_hei;
    assign filt_size  = filter_wid * filter_hei;
    assign row_period = data_wid;    // line buffer wraps once per input row

    assign fb_cnt = filters >> LOG_NPE;
    assign cb_cnt = channels >> LOG_NPE;

    // shifts needed before the first full window sits in the line buffers
    assign win_lat = (filter_hei - 16'd1) * data_wid + filter_wid;

    assign fbrd_delay = win_lat + PIPE_LAT - 16'd1;  // partial sum read one early
    assign fben_delay = fbrd_delay + 16'd1;
    assign wb_delay   = win_lat + PIPE_LAT + FB_LAT;

    // every lane of a group shares one enable, so no partial blocks
    always_comb begin
        if (!$isunknown({channels, filters})) begin
            assert ((channels % N_PE) == 0 && (filters % N_PE) == 0)
                else $error("channels or filters not a multiple of N_PE");
        end
    end

endmodule

//--- conv_block_seq.sv
`timescale 1ns/10ps

module conv_block_seq import conv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  size_t fb_cnt,
    input  size_t cb_cnt,
    input  logic  load_done,
    input  logic  stream_done,
    output size_t fb,
    output size_t cb,
    output logic  last_cb,
    output logic  first_cb_n,
    output logic  load_start,
    output logic  stream_start,
    output logic  done
);

    seq_state_t state;

    assign first_cb_n = (cb != '0);              // feedback add from block 1 on
    assign last_cb    = (cb == cb_cnt - 16'd1);  // bias goes in with this block

    assign load_start   = (state == S_CB) && (cb != cb_cnt);
    assign stream_start = (state == S_PUSH) && load_done;
    assign done         = (state == S_FB) && (fb == fb_cnt);

    //////////////////////////////////////////////////////////////////////
    // nested filter block / channel block loop
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            fb    <= '0;
            cb    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        fb    <= '0;
                        cb    <= '0;
                        state <= S_FB;
                    end
                end
                S_FB: begin
                    if (fb == fb_cnt) begin
                        state <= S_IDLE;  // layer finished
                    end else begin
                        cb    <= '0;
                        state <= S_CB;
                    end
                end
                S_CB: begin
                    if (cb == cb_cnt) begin
                        fb    <= fb + 16'd1;
                        state <= S_FB;
                    end else begin
                        state <= S_SLOT;
                    end
                end
                S_SLOT: state <= S_PUSH;
                S_PUSH: begin
                    if (load_done) begin
                        state <= S_IMG;
                    end
                end
                S_IMG: begin
                    if (stream_done) begin  // last write-back of this pass
                        cb    <= cb + 16'd1;
                        state <= S_CB;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the loader reports back only while the sequencer waits for it
    assert property (@(posedge clk) disable iff (rst)
        load_done |-> (state == S_PUSH))
        else $error("kernel load finished outside the push state");

endmodule

//--- conv_filter_loader.sv
`timescale 1ns/10ps

module conv_filter_loader import conv_pkg::*; #(
    parameter int N_PE = N_PE_DEF
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_start,
    input  logic            last_cb,
    input  size_t           fb,
    input  size_t           cb,
    input  size_t           filt_size,
    input  size_t           cb_cnt,
    input  size_t           in_size,
    input  dim_t            filters,
    output logic            k_rd_en,
    output logic            bias_rd_en,
    output addr_t           k_rd_addr,
    output addr_t           bias_rd_addr,
    output logic [N_PE-1:0] shift_filter,
    output logic [N_PE-1:0] shift_bias,
    output logic            load_done
);

    localparam size_t NPE_S = size_t'(N_PE);

    logic            busy;
    logic            bias_ph;    // reading the bias word of the slot
    size_t           slot;
    size_t           kidx;
    logic            slot_end;
    logic            last_rd;
    logic            last_rd_q;
    logic [N_PE-1:0] slot_oh;

    assign k_rd_en    = busy && !bias_ph;
    assign bias_rd_en = busy && bias_ph;

    // bias only rides along on the last channel block
    assign slot_end = bias_ph || (kidx == filt_size - 16'd1 && !last_cb);
    assign last_rd  = busy && slot_end && (slot == NPE_S - 16'd1);
    assign slot_oh  = N_PE'(1) << slot;

    // kernels sit after all cb_cnt input images in channel block major order
    assign k_rd_addr = cb_cnt * in_size + filt_size * filters * cb
                     + filt_size * (NPE_S * fb + slot) + kidx;
    assign bias_rd_addr = NPE_S * fb + slot;  // one word per filter

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            bias_ph      <= 1'b0;
            slot         <= '0;
            kidx         <= '0;
            last_rd_q    <= 1'b0;
            load_done    <= 1'b0;
            shift_filter <= '0;
            shift_bias   <= '0;
        end else begin
            shift_filter <= k_rd_en ? slot_oh : '0;  // data arrives one cycle later
            shift_bias   <= bias_rd_en ? slot_oh : '0;
            last_rd_q    <= last_rd;
            load_done    <= last_rd_q;
            if (load_start) begin
                busy    <= 1'b1;
                bias_ph <= 1'b0;
                slot    <= '0;
                kidx    <= '0;
            end else if (busy) begin
                if (slot_end) begin
                    kidx    <= '0;
                    bias_ph <= 1'b0;
                    slot    <= slot + 16'd1;
                    if (slot == NPE_S - 16'd1) begin
                        busy <= 1'b0;
                    end
                end else if (kidx == filt_size - 16'd1) begin
                    bias_ph <= 1'b1;
                end else begin
                    kidx <= kidx + 16'd1;
                end
            end
        end
    end

endmodule

//--- conv_image_stream.sv
`timescale 1ns/10ps

module conv_image_stream import conv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stream_start,
    input  size_t cb,
    input  size_t in_size,
    input  size_t win_lat,
    output logic  img_rd_en,
    output logic  shift_line,
    output logic  mac_en,
    output addr_t img_rd_addr
);

    logic  run;
    size_t rd_idx;
    size_t lat_cnt;   // saturates once the window is full

    assign img_rd_en   = run;
    assign img_rd_addr = in_size * cb + rd_idx;   // one image per channel block
    assign mac_en      = run && (lat_cnt == win_lat);

    //////////////////////////////////////////////////////////////////////
    // read pointer and window fill counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run        <= 1'b0;
            rd_idx     <= '0;
            lat_cnt    <= '0;
            shift_line <= 1'b0;
        end else begin
            shift_line <= img_rd_en;   // word lands in the line buffer next cycle
            if (stream_start) begin
                run     <= 1'b1;
                rd_idx  <= '0;
                lat_cnt <= '0;
            end else if (run) begin
                rd_idx <= rd_idx + 16'd1;
                if (lat_cnt != win_lat) begin
                    lat_cnt <= lat_cnt + 16'd1;
                end
                if (rd_idx == in_size - 16'd1) begin
                    run <= 1'b0;
                end
            end
        end
    end

    // the array must have seen line data when the window opens
    assert property (@(posedge clk) disable iff (rst)
        $rose(mac_en) |-> shift_line)
        else $error("mac_en raised before any line shift");

endmodule

//--- conv_stage_gate.sv
`timescale 1ns/10ps

module conv_stage_gate import conv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stage_start,
    input  logic  active,
    input  size_t delay,
    input  size_t row_period,
    input  size_t out_wid,
    input  size_t out_size,
    input  size_t fb,
    output logic  strobe,
    output logic  finished,
    output addr_t addr
);

    logic  wait_on;
    logic  run;
    logic  gate;
    size_t dly_cnt;
    size_t col;
    size_t idx;

    assign gate     = (col < out_wid);   // low on wrap-around columns
    assign strobe   = run && gate && active;
    assign finished = run && gate && (idx == out_size - 16'd1);
    assign addr     = out_size * fb + idx;   // holds still while gated

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_on <= 1'b0;
            run     <= 1'b0;
            dly_cnt <= '0;
            col     <= '0;
            idx     <= '0;
        end else if (stage_start) begin
            wait_on <= 1'b1;
            run     <= 1'b0;
            dly_cnt <= '0;
            col     <= '0;
            idx     <= '0;
        end else if (wait_on) begin
            if (dly_cnt == delay - 16'd1) begin
                wait_on <= 1'b0;
                run     <= 1'b1;
            end else begin
                dly_cnt <= dly_cnt + 16'd1;
            end
        end else if (run) begin
            col <= (col == row_period - 16'd1) ? '0 : col + 16'd1;
            if (gate) begin
                idx <= idx + 16'd1;
            end
            if (finished) begin
                run <= 1'b0;
            end
        end
    end

endmodule

//--- conv_ctrl.sv
`timescale 1ns/10ps

module conv_ctrl import conv_pkg::*; #(
    parameter int N_PE         = N_PE_DEF,
    parameter int LAT_MAC      = LAT_MAC_DEF,
    parameter int LAT_ADD_TREE = LAT_ADD_TREE_DEF,
    parameter int LAT_FB_ADD   = LAT_FB_ADD_DEF
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  dim_t            data_wid,
    input  dim_t            data_hei,
    input  dim_t            filter_wid,
    input  dim_t            filter_hei,
    input  dim_t            channels,
    input  dim_t            filters,
    // buffer 1
    output logic            k_rd_en,
    output addr_t           k_rd_addr,
    output logic            bias_rd_en,
    output addr_t           bias_rd_addr,
    output logic            img_rd_en,
    output addr_t           img_rd_addr,
    // buffer 2
    output logic            wb_en,
    output addr_t           wb_addr,
    output logic            fb_rd_en,
    output addr_t           fb_rd_addr,
    // PE array
    output logic            fb_add_en,
    output logic [N_PE-1:0] shift_filter,
    output logic [N_PE-1:0] shift_bias,
    output logic            shift_line,
    output logic            mac_en,
    output logic            done
);

    size_t in_size, out_wid, out_size, filt_size, row_period;
    size_t fb_cnt, cb_cnt, win_lat;
    size_t wb_delay, fbrd_delay, fben_delay;
    size_t fb, cb;
    logic  last_cb, first_cb_n;
    logic  load_start, load_done;
    logic  stream_start, stream_done;

    conv_geometry #(
        .N_PE(N_PE), .LAT_MAC(LAT_MAC), .LAT_ADD_TREE(LAT_ADD_TREE), .LAT_FB_ADD(LAT_FB_ADD)
    ) u_geometry (
        .data_wid, .data_hei, .filter_wid, .filter_hei, .channels, .filters,
        .in_size, .out_wid, .out_size, .filt_size, .row_period,
        .fb_cnt, .cb_cnt, .win_lat, .wb_delay, .fbrd_delay, .fben_delay
    );

    conv_block_seq u_block_seq (
        .clk, .rst, .start, .fb_cnt, .cb_cnt, .load_done, .stream_done,
        .fb, .cb, .last_cb, .first_cb_n, .load_start, .stream_start, .done
    );

    conv_filter_loader #(.N_PE(N_PE)) u_filter_loader (
        .clk, .rst, .load_start, .last_cb, .fb, .cb, .filt_size, .cb_cnt, .in_size,
        .filters, .k_rd_en, .bias_rd_en, .k_rd_addr, .bias_rd_addr,
        .shift_filter, .shift_bias, .load_done
    );

    conv_image_stream u_image_stream (
        .clk, .rst, .stream_start, .cb, .in_size, .win_lat,
        .img_rd_en, .shift_line, .mac_en, .img_rd_addr
    );

    //////////////////////////////////////////////////////////////////////
    // output stages
    //////////////////////////////////////////////////////////////////////
    conv_stage_gate u_wb_gate (     // write-back closes the pass
        .clk, .rst, .stage_start(stream_start), .active(1'b1), .delay(wb_delay),
        .row_period, .out_wid, .out_size, .fb,
        .strobe(wb_en), .finished(stream_done), .addr(wb_addr)
    );

    conv_stage_gate u_fbrd_gate (   // partial sums back from buffer 2
        .clk, .rst, .stage_start(stream_start), .active(first_cb_n), .delay(fbrd_delay),
        .row_period, .out_wid, .out_size, .fb,
        .strobe(fb_rd_en), .finished(), .addr(fb_rd_addr)
    );

    conv_stage_gate u_fben_gate (
        .clk, .rst, .stage_start(stream_start), .active(first_cb_n), .delay(fben_delay),
        .row_period, .out_wid, .out_size, .fb,
        .strobe(fb_add_en), .finished(), .addr()
    );

endmodule

//--- tb_conv_ctrl.sv
`timescale 1ns/10ps

module tb_conv_ctrl import conv_pkg::*; ();

    localparam int NPE      = N_PE_DEF;
    localparam int N_LAYERS = 2;

    // data w/h, filter w/h, channels and filters of each layer
    int lay_dw [N_LAYERS] = '{6, 7};
    int lay_dh [N_LAYERS] = '{5, 4};
    int lay_fw [N_LAYERS] = '{3, 2};
    int lay_fh [N_LAYERS] = '{3, 2};
    int lay_ch [N_LAYERS] = '{8, 4};
    int lay_fl [N_LAYERS] = '{8, 8};

    logic           clk;
    logic           rst;
    logic           start;
    dim_t           data_wid, data_hei, filter_wid, filter_hei, channels, filters;
    logic           k_rd_en, bias_rd_en, img_rd_en, wb_en, fb_rd_en, fb_add_en;
    addr_t          k_rd_addr, bias_rd_addr, img_rd_addr, wb_addr, fb_rd_addr;
    logic [NPE-1:0] shift_filter, shift_bias;
    logic           shift_line, mac_en, done;

    int    seed        = 88;
    int    cycles      = 0;
    int    cycle_limit = 0;
    string test_name   = "reset";

    // one queue of expected strobes per output group
    addr_t k_addr_q[$];
    int    k_slot_q[$];
    addr_t bias_addr_q[$];
    int    bias_slot_q[$];
    addr_t img_q[$];
    addr_t wb_q[$];
    addr_t fbrd_q[$];

    logic quiet     = 1'b1;   // no layer running
    logic k_prev    = 1'b0;
    logic b_prev    = 1'b0;
    logic img_prev  = 1'b0;
    logic fbrd_prev = 1'b0;
    int   k_slot_prev, b_slot_prev;
    int   mac_pass, bias_cnt, wb_cnt, fbrd_cnt, fbadd_cnt, pass_cnt;
    int   pass_idx;           // image passes started in this layer
    int   done_cnt = 0;
    int   exp_in_size, exp_win_lat;
    int   exp_cbc  = 1;

    conv_ctrl #(.N_PE(NPE)) u_conv_ctrl (
        .clk, .rst, .start, .data_wid, .data_hei, .filter_wid, .filter_hei,
        .channels, .filters, .k_rd_en, .k_rd_addr, .bias_rd_en, .bias_rd_addr,
        .img_rd_en, .img_rd_addr, .wb_en, .wb_addr, .fb_rd_en, .fb_rd_addr,
        .fb_add_en, .shift_filter, .shift_bias, .shift_line, .mac_en, .done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    function automatic int kernel_addr(input int fb, cb, slot, k, fs, fl, cbc, in_sz);
        return cbc * in_sz + fs * fl * cb + fs * (NPE * fb + slot) + k;
    endfunction

    function automatic int bias_addr(input int fb, slot);
        return NPE * fb + slot;
    endfunction

    function automatic int out_addr(input int fb, idx, osz);
        return osz * fb + idx;   // same rule for write-back and feedback read
    endfunction

    function automatic int layer_budget(input int li);
        int in_sz;
        int wl;
        in_sz = lay_dw[li] * lay_dh[li];
        wl    = (lay_fh[li] - 1) * lay_dw[li] + lay_fw[li];
        return (lay_fl[li] / NPE) * (lay_ch[li] / NPE)
             * (NPE * (lay_fw[li] * lay_fh[li] + 3) + in_sz
                + wl + LAT_MAC_DEF + LAT_ADD_TREE_DEF + LAT_FB_ADD_DEF + 10);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input size_t exp, input size_t act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                test_name, what, exp, act));
        end
    endtask

    task automatic check_lanes(input string what, input logic [NPE-1:0] exp,
                               input logic [NPE-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                test_name, what, exp, act));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor samples mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        logic [NPE-1:0] lanes;
        if (quiet && (k_rd_en || bias_rd_en || img_rd_en || wb_en || fb_rd_en
                      || fb_add_en || shift_line || mac_en
                      || (|shift_filter) || (|shift_bias))) begin
            stop_run("a strobe fired while no layer was running");
        end
        lanes = k_prev ? (NPE'(1) << k_slot_prev) : '0;   // one cycle after the read
        check_lanes("shift_filter", lanes, shift_filter);
        lanes = b_prev ? (NPE'(1) << b_slot_prev) : '0;
        check_lanes("shift_bias", lanes, shift_bias);
        k_prev = k_rd_en;
        b_prev = bias_rd_en;
        if (k_rd_en) begin
            if (k_addr_q.size() == 0) stop_run("kernel read beyond the expected sequence");
            check_addr("k_rd_addr", k_addr_q.pop_front(), k_rd_addr);
            k_slot_prev = k_slot_q.pop_front();
        end
        if (bias_rd_en) begin
            if (bias_addr_q.size() == 0) stop_run("bias read beyond the expected sequence");
            if (pass_idx % exp_cbc != exp_cbc - 1) begin   // pass not started yet
                stop_run("bias read outside the last channel block");
            end
            check_addr("bias_rd_addr", bias_addr_q.pop_front(), bias_rd_addr);
            b_slot_prev = bias_slot_q.pop_front();
            bias_cnt++;
        end
        if (shift_line !== img_prev) stop_run("shift_line did not trail img_rd_en by one cycle");
        if (mac_en) mac_pass++;
        if (img_prev && !img_rd_en) begin   // end of one image pass
            check_count("mac_en cycles per pass", size_t'(exp_in_size - exp_win_lat),
                size_t'(mac_pass));
            mac_pass = 0;
            pass_cnt++;
        end
        if (img_rd_en && !img_prev) pass_idx++;
        img_prev = img_rd_en;
        if (img_rd_en) begin
            if (img_q.size() == 0) stop_run("image read beyond the expected sequence");
            check_addr("img_rd_addr", img_q.pop_front(), img_rd_addr);
        end
        if (wb_en) begin
            if (wb_q.size() == 0) stop_run("write-back beyond the expected sequence");
            check_addr("wb_addr", wb_q.pop_front(), wb_addr);
            wb_cnt++;
        end
        if (fb_add_en !== fbrd_prev) stop_run("fb_add_en did not trail fb_rd_en by one cycle");
        fbrd_prev = fb_rd_en;
        if (fb_add_en) begin
            if ((pass_idx - 1) % exp_cbc == 0) begin
                stop_run("feedback add on the first channel block");
            end
            fbadd_cnt++;
        end
        if (fb_rd_en) begin
            if (fbrd_q.size() == 0) stop_run("feedback read beyond the expected sequence");
            if ((pass_idx - 1) % exp_cbc == 0) begin
                stop_run("feedback read on the first channel block");
            end
            check_addr("fb_rd_addr", fbrd_q.pop_front(), fb_rd_addr);
            fbrd_cnt++;
        end
        if (done) begin
            if (quiet) stop_run("done pulsed with no layer running");
            done_cnt++;
            quiet = 1'b1;
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            stop_run($sformatf("timeout, layer did not finish within %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic run_layer(input int li);
        int in_sz, ow, osz, fs, fbc, cbc, gap;
        in_sz       = lay_dw[li] * lay_dh[li];
        ow          = lay_dw[li] - lay_fw[li] + 1;
        osz         = ow * (lay_dh[li] - lay_fh[li] + 1);
        fs          = lay_fw[li] * lay_fh[li];
        fbc         = lay_fl[li] / NPE;
        cbc         = lay_ch[li] / NPE;
        exp_in_size = in_sz;
        exp_win_lat = (lay_fh[li] - 1) * lay_dw[li] + lay_fw[li];
        exp_cbc     = cbc;
        test_name   = $sformatf("layer%0d", li);
        for (int fb = 0; fb < fbc; fb++) begin
            for (int cb = 0; cb < cbc; cb++) begin
                for (int slot = 0; slot < NPE; slot++) begin
                    for (int k = 0; k < fs; k++) begin
                        k_addr_q.push_back(addr_t'(kernel_addr(fb, cb, slot, k, fs,
                            lay_fl[li], cbc, in_sz)));
                        k_slot_q.push_back(slot);
                    end
                    if (cb == cbc - 1) begin   // bias rides on the last block
                        bias_addr_q.push_back(addr_t'(bias_addr(fb, slot)));
                        bias_slot_q.push_back(slot);
                    end
                end
                for (int i = 0; i < in_sz; i++) img_q.push_back(addr_t'(in_sz * cb + i));
                for (int i = 0; i < osz; i++) begin
                    wb_q.push_back(addr_t'(out_addr(fb, i, osz)));
                    if (cb > 0) fbrd_q.push_back(addr_t'(out_addr(fb, i, osz)));
                end
            end
        end
        mac_pass  = 0;
        bias_cnt  = 0;
        wb_cnt    = 0;
        fbrd_cnt  = 0;
        fbadd_cnt = 0;
        pass_cnt  = 0;
        pass_idx  = 0;
        @(posedge clk);
        data_wid   <= dim_t'(lay_dw[li]);
        data_hei   <= dim_t'(lay_dh[li]);
        filter_wid <= dim_t'(lay_fw[li]);
        filter_hei <= dim_t'(lay_fh[li]);
        channels   <= dim_t'(lay_ch[li]);
        filters    <= dim_t'(lay_fl[li]);
        gap = ($random(seed) & 15) + 2;
        repeat (gap) @(posedge clk);
        start <= 1'b1;
        quiet = 1'b0;
        @(posedge clk);
        start <= 1'b0;
        wait (done_cnt == li + 1);
        @(posedge clk);
        check_count("kernel reads missing", size_t'(0), size_t'(k_addr_q.size()));
        check_count("bias reads", size_t'(fbc * NPE), size_t'(bias_cnt));
        check_count("image passes", size_t'(fbc * cbc), size_t'(pass_cnt));
        check_count("image reads missing", size_t'(0), size_t'(img_q.size()));
        check_count("write-back strobes", size_t'(fbc * cbc * osz), size_t'(wb_cnt));
        check_count("feedback reads", size_t'(fbc * (cbc - 1) * osz), size_t'(fbrd_cnt));
        check_count("feedback adds", size_t'(fbc * (cbc - 1) * osz), size_t'(fbadd_cnt));
    endtask

    initial begin
        rst        <= 1'b1;
        start      <= 1'b0;
        data_wid   <= '0;
        data_hei   <= '0;
        filter_wid <= '0;
        filter_hei <= '0;
        channels   <= '0;
        filters    <= '0;
        for (int li = 0; li < N_LAYERS; li++) cycle_limit += layer_budget(li);
        cycle_limit = cycle_limit * 2;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int li = 0; li < N_LAYERS; li++) run_layer(li);
        repeat (20) @(posedge clk);   // monitor keeps watching the idle tail
        if (done_cnt == N_LAYERS && bias_addr_q.size() == 0 && fbrd_q.size() == 0
            && wb_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run("layers ended with expected strobes still pending");
        end
    end

endmodule

//--- verilog.f
conv_pkg.sv
conv_geometry.sv
conv_block_seq.sv
conv_filter_loader.sv
conv_image_stream.sv
conv_stage_gate.sv
conv_ctrl.sv
tb_conv_ctrl.sv

//--- Makefile
SIM  = obj_dir/Vtb_conv_ctrl
SRCS = $(shell cat verilog.f)

.PHONY: run clean

run: $(SIM)
	$(SIM) | awk '{ print } $$0 == "ALL CHECKS PASSED" { ok = 1 } END { exit !ok }'

$(SIM): $(SRCS) verilog.f
	verilator --binary --timing --assert -j 0 --top-module tb_conv_ctrl -f verilog.f

clean:
	rm -rf obj_dir
